// ==== bench/lsu_checker.sv ====
`timescale 1ns/1ns

module lsu_checker
  import rv32v_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      cmd_valid,
  input  logic      cmd_ready,
  input  logic      mem_ren,
  input  logic      mem_wen,
  input  logic      dhit,
  input  logic      exception,
  input  logic      busy,
  input  logic      result_valid,
  input  addr_t     mem_addr,
  input  word_t     mem_wdata,
  input  byte_ena_t mem_byte_ena,
  input  word_t     result0,
  input  word_t     result1,
  output logic      done,
  output int        run_count,
  output int        fail_count
);

  localparam int TIMEOUT = 40;

  // Tests in command order.
  string name_q[$];
  string op_q[$];
  string code_q[$];
  addr_t addr0_q[$];
  addr_t addr1_q[$];
  sew_t  sew_q[$];
  word_t data0_q[$];
  word_t data1_q[$];

  // Access seen in the last hit cycle.
  logic      h_ren;
  logic      h_wen;
  logic      h_busy;
  addr_t     h_addr;
  word_t     h_wdata;
  byte_ena_t h_bena;

  int test_errs;
  int stall_cycles = 0;

  // Queued by the testbench while it reads the data file.
  task automatic add_test(input string name, input string op, input addr_t base,
                          input addr_t stride, input sew_t sew, input word_t d0,
                          input word_t d1, input string code);
    name_q.push_back(name);
    op_q.push_back(op);
    code_q.push_back(code);
    addr0_q.push_back(base);
    addr1_q.push_back(base + stride);
    sew_q.push_back(sew);
    data0_q.push_back(d0);
    data1_q.push_back(d1);
  endtask

  // ************************************************************
  // Reference rules.
  // ************************************************************

  // Memory model read data.
  function automatic word_t mem_data(input addr_t a);
    return a ^ 32'hA5A5_0000;
  endfunction

  // Element bits kept, upper bits zero.
  function automatic word_t width_mask(input sew_t sew);
    case (sew)
      2'd0:    return 32'h0000_00ff;
      2'd1:    return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // Access size code follows the width code.
  function automatic byte_ena_t size_code(input sew_t sew);
    return (sew == 2'd3) ? 2'd2 : sew;
  endfunction

  task automatic compare_value(input string name, input string what,
                               input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv)
    begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, expv, actv);
      test_errs++;
    end
  endtask

  task automatic report_test(input string name);
    run_count++;
    if (test_errs == 0)
      $display("PASS %s", name);
    else
    begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  // ************************************************************
  // Waits on the memory port.
  // ************************************************************

  // Next completed access, sampled in its hit cycle.
  task automatic wait_hit(input string name, output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
      if ((mem_ren || mem_wen) && dhit)
      begin
        ok      = 1'b1;
        h_ren   = mem_ren;
        h_wen   = mem_wen;
        h_busy  = busy;
        h_addr  = mem_addr;
        h_wdata = mem_wdata;
        h_bena  = mem_byte_ena;
      end
    end
    if (!ok)
    begin
      $display("%s: no memory access completed within %0d cycles", name, TIMEOUT);
      test_errs++;
    end
  endtask

  // Exception with no traffic before it, then cleared by returnex.
  task automatic wait_exception(input string name, output logic ok);
    int cycles;
    int req_cycles;
    cycles     = 0;
    req_cycles = 0;
    ok         = 1'b0;
    while (!ok && cycles < TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
      if (exception)
        ok = 1'b1;
      else if (mem_ren || mem_wen)
        req_cycles++;
    end
    if (!ok)
    begin
      $display("%s: exception did not rise within %0d cycles", name, TIMEOUT);
      test_errs++;
    end
    if (req_cycles != 0)
    begin
      $display("%s: memory was accessed before the exception", name);
      test_errs++;
    end
    cycles = 0;
    while (ok && exception && cycles < TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
    end
    if (ok && exception)
    begin
      $display("%s: exception was not cleared by returnex", name);
      test_errs++;
      ok = 1'b0;
    end
  endtask

  // One element access against the command.
  task automatic check_access(input int i, input int elem);
    logic is_load;
    is_load = (op_q[i] == "L");
    compare_value(name_q[i], "mem_ren", is_load, h_ren);
    compare_value(name_q[i], "mem_wen", !is_load, h_wen);
    compare_value(name_q[i], "busy", 1'b1, h_busy);
    compare_value(name_q[i], "mem_addr", (elem == 0) ? addr0_q[i] : addr1_q[i], h_addr);
    compare_value(name_q[i], "mem_byte_ena", size_code(sew_q[i]), h_bena);
    if (!is_load)
      compare_value(name_q[i], "mem_wdata", (elem == 0) ? data0_q[i] : data1_q[i], h_wdata);
  endtask

  task automatic run_test(input int i, output logic ok);
    int cycles;
    test_errs = 0;
    if (code_q[i] == "EXC0")
      wait_exception(name_q[i], ok);
    else
    begin
      wait_hit(name_q[i], ok);
      if (ok)
        check_access(i, 0);
      // Second address is bad, so only one access.
      if (ok && code_q[i] == "EXC1")
        wait_exception(name_q[i], ok);
      else if (ok)
      begin
        wait_hit(name_q[i], ok);
        if (ok)
          check_access(i, 1);
      end
      if (ok && code_q[i] == "OK" && op_q[i] == "L")
      begin
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < TIMEOUT)
        begin
          @(posedge CLK);
          cycles++;
          ok = result_valid;
        end
        if (!ok)
        begin
          $display("%s: result_valid did not pulse within %0d cycles", name_q[i], TIMEOUT);
          test_errs++;
        end
        else
        begin
          compare_value(name_q[i], "result0",
                        mem_data(addr0_q[i]) & width_mask(sew_q[i]), result0);
          compare_value(name_q[i], "result1",
                        mem_data(addr1_q[i]) & width_mask(sew_q[i]), result1);
        end
      end
    end
  endtask

  // Cycles where a command waits on a full stage.
  always @(posedge CLK)
  begin
    if (nRST === 1'b1 && cmd_valid && !cmd_ready)
      stall_cycles++;
  end

  // ************************************************************
  // Test sequence.
  // ************************************************************

  initial
  begin
    int   cycles;
    logic ok;
    done       = 1'b0;
    run_count  = 0;
    fail_count = 0;
    cycles     = 0;
    ok         = 1'b1;
    while (nRST !== 1'b1 && cycles < TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
    end
    // Idle outputs right after reset.
    test_errs = 0;
    if (nRST !== 1'b1)
    begin
      $display("reset_state: reset was never released");
      test_errs++;
      ok = 1'b0;
    end
    compare_value("reset_state", "cmd_ready", 1'b1, cmd_ready);
    compare_value("reset_state", "mem_ren", 1'b0, mem_ren);
    compare_value("reset_state", "mem_wen", 1'b0, mem_wen);
    compare_value("reset_state", "result_valid", 1'b0, result_valid);
    compare_value("reset_state", "exception", 1'b0, exception);
    compare_value("reset_state", "busy", 1'b0, busy);
    report_test("reset_state");
    for (int i = 0; i < name_q.size() && ok; i++)
    begin
      run_test(i, ok);
      report_test(name_q[i]);
    end
    // Back-to-back commands must have stalled at least once.
    if (ok)
    begin
      test_errs = 0;
      if (stall_cycles == 0)
      begin
        $display("back_pressure: cmd_ready never dropped while a command waited");
        test_errs++;
      end
      report_test("back_pressure");
    end
    done = 1'b1;
  end

endmodule

// ==== bench/vector_lsu_input.txt ====
# name op base stride sew data0 data1 result
# Hex base, stride and data; sew 0/1/2 is 8/16/32 bits; result is OK, EXC0 or EXC1.
load_sew8        L 000010fc 00000010 0 00000000 00000000 OK
load_sew16       L 00002468 00000008 1 00000000 00000000 OK
load_sew32       L 00003abc 00000004 2 00000000 00000000 OK
store_sew8       S 00004000 00000004 0 000000a5 0000005a OK
store_sew16      S 00004100 00000020 1 0000beef 0000cafe OK
store_sew32      S 00004200 fffffffc 2 12345678 9abcdef0 OK
misalign_base    L 00005002 00000004 2 00000000 00000000 EXC0
after_base_exc   L 00005010 00000004 2 00000000 00000000 OK
misalign_second  S 00006000 00000006 1 11112222 33334444 EXC1
after_second_exc S 00006100 00000008 2 55556666 77778888 OK
misalign_ld_2nd  L 00006200 00000001 0 00000000 00000000 EXC1
burst_load0      L 00007000 00000040 2 00000000 00000000 OK
burst_store0     S 00007100 00000004 2 deadbeef 0badf00d OK
burst_load1      L 00007ffc 00000004 1 00000000 00000000 OK
misalign_st_base S 00008003 00000004 0 000000ff 000000ee EXC0
burst_load2      L 00009f00 00000100 0 00000000 00000000 OK

// ==== bench/vector_lsu_properties.sv ====
`timescale 1ns/1ns

module vector_lsu_properties
  import rv32v_types_pkg::*;
(
  input logic      CLK,
  input logic      nRST,
  input logic      ren,
  input logic      wen,
  input logic      busy,
  input logic      exception,
  input logic      dhit,
  input addr_t     final_addr,
  input word_t     final_storedata,
  input byte_ena_t byte_ena
);

  // Failed assertions, read by the testbench at the end.
  int assert_fails = 0;

  // ************************************************************
  // Scheduler protocol rules.
  // ************************************************************

  // One direction at a time.
  assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
  else
  begin
    assert_fails = assert_fails + 1;
    $error("ren and wen are both high");
  end

  // EX is never counted as busy.
  assert property (@(posedge CLK) disable iff (!nRST) exception |-> !busy)
  else
  begin
    assert_fails = assert_fails + 1;
    $error("exception is high while busy");
  end

  // Request held unchanged until its hit.
  assert property (@(posedge CLK) disable iff (!nRST)
    (ren || wen) && !dhit |=> $stable({ren, wen, final_addr, final_storedata, byte_ena}))
  else
  begin
    assert_fails = assert_fails + 1;
    $error("memory request changed before dhit");
  end

endmodule

bind address_scheduler vector_lsu_properties props0 (.*);

// ==== bench/vector_lsu_tb.sv ====
`timescale 1ns/1ns

module vector_lsu_tb
  import rv32v_types_pkg::*;
;

  localparam int CMD_TIMEOUT  = 60;
  localparam int DONE_TIMEOUT = 200;

  logic      CLK;
  logic      nRST;
  logic      cmd_valid;
  logic      cmd_load;
  logic      cmd_store;
  logic      dhit;
  logic      returnex;
  addr_t     base;
  addr_t     stride;
  sew_t      cmd_sew;
  word_t     cmd_data0;
  word_t     cmd_data1;
  word_t     mem_rdata;
  logic      cmd_ready;
  logic      busy;
  logic      mem_ren;
  logic      mem_wen;
  logic      exception;
  logic      result_valid;
  addr_t     mem_addr;
  word_t     mem_wdata;
  byte_ena_t mem_byte_ena;
  word_t     result0;
  word_t     result1;

  // Checker status.
  logic chk_done;
  int   chk_runs;
  int   chk_fails;
  int   tb_errors;

  // Commands from the data file.
  string name_q[$];
  string op_q[$];
  addr_t base_q[$];
  addr_t stride_q[$];
  sew_t  sew_q[$];
  word_t d0_q[$];
  word_t d1_q[$];

  vector_lsu dut0 (.*);

  lsu_checker chk0 (
    .CLK          (CLK),
    .nRST         (nRST),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .dhit         (dhit),
    .exception    (exception),
    .busy         (busy),
    .result_valid (result_valid),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_byte_ena (mem_byte_ena),
    .result0      (result0),
    .result1      (result1),
    .done         (chk_done),
    .run_count    (chk_runs),
    .fail_count   (chk_fails)
  );

  // 100 ns clock.
  initial
  begin
    CLK = 1'b0;
    forever
      #50 CLK = ~CLK;
  end

  // ************************************************************
  // Memory model with random latency.
  // ************************************************************

  initial
  begin
    int unsigned seed;
    int unsigned delay;
    logic        active;
    seed      = $urandom(32'h711b_5af6);
    dhit      = 1'b0;
    mem_rdata = '0;
    active    = 1'b0;
    delay     = 0;
    forever
    begin
      @(negedge CLK);
      // Last access completed on the rising edge.
      if (dhit)
      begin
        dhit   = 1'b0;
        active = 1'b0;
      end
      // New request, 0 to 3 extra cycles.
      if ((mem_ren || mem_wen) && !active)
      begin
        active = 1'b1;
        delay  = $urandom % 4;
      end
      if (active && delay == 0)
      begin
        dhit      = 1'b1;
        mem_rdata = mem_addr ^ 32'hA5A5_0000;
      end
      else if (active)
        delay = delay - 1;
    end
  end

  // Core answers an exception after it held for a cycle.
  initial
  begin
    logic held;
    returnex = 1'b0;
    held     = 1'b0;
    forever
    begin
      @(negedge CLK);
      returnex = exception && held;
      held     = exception && !returnex;
    end
  end

  // ************************************************************
  // Stimulus.
  // ************************************************************

  initial
  begin
    int    fd;
    int    got;
    int    cycles;
    int    rd_sew;
    logic  accepted;
    string line;
    string rd_name;
    string rd_op;
    string rd_code;
    addr_t rd_base;
    addr_t rd_stride;
    word_t rd_d0;
    word_t rd_d1;
    nRST      = 1'b0;
    cmd_valid = 1'b0;
    cmd_load  = 1'b0;
    cmd_store = 1'b0;
    base      = '0;
    stride    = '0;
    cmd_sew   = '0;
    cmd_data0 = '0;
    cmd_data1 = '0;
    tb_errors = 0;
    // Load every test before reset ends.
    fd = $fopen("bench/vector_lsu_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open bench/vector_lsu_input.txt");
      tb_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        got  = $fgets(line, fd);
        if (got > 0 && line.len() > 1 && line.getc(0) != "#")
        begin
          got = $sscanf(line, "%s %s %h %h %d %h %h %s", rd_name, rd_op, rd_base,
                        rd_stride, rd_sew, rd_d0, rd_d1, rd_code);
          if (got == 8)
          begin
            name_q.push_back(rd_name);
            op_q.push_back(rd_op);
            base_q.push_back(rd_base);
            stride_q.push_back(rd_stride);
            sew_q.push_back(sew_t'(rd_sew));
            d0_q.push_back(rd_d0);
            d1_q.push_back(rd_d1);
            chk0.add_test(rd_name, rd_op, rd_base, rd_stride, sew_t'(rd_sew),
                          rd_d0, rd_d1, rd_code);
          end
        end
      end
      $fclose(fd);
    end
    repeat (4) @(negedge CLK);
    nRST = 1'b1;
    // Commands back to back, each held until accepted.
    for (int i = 0; i < base_q.size() && tb_errors == 0; i++)
    begin
      @(negedge CLK);
      cmd_valid = 1'b1;
      cmd_load  = (op_q[i] == "L");
      cmd_store = (op_q[i] != "L");
      base      = base_q[i];
      stride    = stride_q[i];
      cmd_sew   = sew_q[i];
      cmd_data0 = d0_q[i];
      cmd_data1 = d1_q[i];
      accepted  = 1'b0;
      cycles    = 0;
      while (!accepted && cycles < CMD_TIMEOUT)
      begin
        @(posedge CLK);
        cycles++;
        accepted = cmd_ready;
      end
      if (!accepted)
      begin
        $display("Command %s was not accepted within %0d cycles", name_q[i], CMD_TIMEOUT);
        tb_errors++;
      end
    end
    @(negedge CLK);
    cmd_valid = 1'b0;
    cmd_load  = 1'b0;
    cmd_store = 1'b0;
    cycles    = 0;
    while (!chk_done && cycles < DONE_TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
    end
    if (!chk_done)
    begin
      $display("Checker did not finish within %0d cycles", DONE_TIMEOUT);
      tb_errors++;
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d, bench errors: %0d",
             chk_runs, chk_runs - chk_fails, chk_fails,
             dut0.u_sched.props0.assert_fails, tb_errors);
    if (tb_errors == 0 && chk_fails == 0 && dut0.u_sched.props0.assert_fails == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== src/address_generator.sv ====
`timescale 1ns/1ns
`include "vlsu_params.svh"

module address_generator
  import rv32v_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  cmd_valid,
  input  logic  cmd_load,
  input  logic  cmd_store,
  input  logic  take,
  input  addr_t base,
  input  addr_t stride,
  input  sew_t  cmd_sew,
  input  word_t cmd_data0,
  input  word_t cmd_data1,
  output logic  cmd_ready,
  output logic  req_load,
  output logic  req_store,
  output addr_t addr0,
  output addr_t addr1,
  output word_t storedata0,
  output word_t storedata1,
  output sew_t  sew
);

  // Command handshake.
  logic  accept;
  logic  empty;
  // Second element address.
  addr_t next_addr1;

  // Stage is empty when no direction is pending.
  assign empty = !(req_load || req_store);

  // Free now, or freed by the scheduler this cycle.
  assign cmd_ready = empty || take;
  assign accept    = cmd_valid && cmd_ready;

  // Element 1 sits one stride above the base.
  assign next_addr1 = base + stride;

  // ************************************************************
  // Stage occupancy.
  // ************************************************************

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      req_load  <= 1'b0;
      req_store <= 1'b0;
    end
    else if (accept)
    begin
      // A new command replaces the one being taken.
      req_load  <= cmd_load;
      req_store <= cmd_store;
    end
    else if (take)
    begin
      // Handed over, nothing behind it.
      req_load  <= 1'b0;
      req_store <= 1'b0;
    end
  end

  // Command payload, only meaningful while occupied.
  always_ff @(posedge CLK)
  begin
    if (accept)
    begin
      addr0      <= base;
      addr1      <= next_addr1;
      storedata0 <= cmd_data0;
      storedata1 <= cmd_data1;
      sew        <= cmd_sew;
    end
  end

endmodule

// ==== src/address_scheduler.sv ====
`timescale 1ns/1ns
`include "vlsu_params.svh"

module address_scheduler
  import rv32v_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      load,
  input  logic      store,
  input  logic      dhit,
  input  logic      returnex,
  input  addr_t     addr0,
  input  addr_t     addr1,
  input  word_t     storedata0,
  input  word_t     storedata1,
  input  sew_t      sew,
  output logic      take,
  output logic      ren,
  output logic      wen,
  output logic      busy,
  output logic      exception,
  output logic      arrived0,
  output logic      arrived1,
  output addr_t     final_addr,
  output word_t     final_storedata,
  output byte_ena_t byte_ena
);

  sched_state_t state, next_state;

  // Request and alignment flags.
  logic daccess;
  logic misalign0;
  logic misalign1;

  // Command copy, so stage 1 can refill behind us.
  addr_t addr0_q;
  addr_t addr1_q;
  word_t data0_q;
  word_t data1_q;
  sew_t  sew_q;

  // ************************************************************
  // Request decode.
  // ************************************************************

  assign daccess = load || store;

  // One cycle in IDLE with a request pending.
  assign take = (state == IDLE) && daccess;

  // Word alignment only, low two bits must be zero.
  assign misalign0 = (addr0[1:0] != 2'b00) && daccess;
  assign misalign1 = addr1_q[1:0] != 2'b00;

  // Load data valid in the hit cycle.
  assign arrived0 = (state == LOAD0) && dhit;
  assign arrived1 = (state == LOAD1) && dhit;

  // Access size follows the element width.
  always_comb
  begin
    case (sew_q)
      `VLSU_SEW8:  byte_ena = `VLSU_BENA8;
      `VLSU_SEW16: byte_ena = `VLSU_BENA16;
      default:     byte_ena = `VLSU_BENA32;
    endcase
  end

  // Captured when the command is taken.
  always_ff @(posedge CLK)
  begin
    if (take)
    begin
      addr0_q <= addr0;
      addr1_q <= addr1;
      data0_q <= storedata0;
      data1_q <= storedata1;
      sew_q   <= sew;
    end
  end

  // ************************************************************
  // State machine.
  // ************************************************************

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        // Bad base never touches memory.
        if (misalign0)
          next_state = EX;
        else if (load)
          next_state = LOAD0;
        else if (store)
          next_state = STORE0;
      end
      LOAD0:
      begin
        // Second address checked once the first has hit.
        if (dhit && misalign1)
          next_state = EX;
        else if (dhit)
          next_state = LOAD1;
      end
      LOAD1:
      begin
        if (dhit)
          next_state = IDLE;
      end
      STORE0:
      begin
        if (dhit && misalign1)
          next_state = EX;
        else if (dhit)
          next_state = STORE1;
      end
      STORE1:
      begin
        if (dhit)
          next_state = IDLE;
      end
      EX:
      begin
        if (returnex)
          next_state = IDLE;
      end
      default:
        next_state = IDLE;
    endcase
  end

  // Memory request and status outputs.
  always_comb
  begin
    final_addr      = '0;
    final_storedata = '0;
    ren             = 1'b0;
    wen             = 1'b0;
    busy            = 1'b1;
    exception       = 1'b0;
    case (state)
      IDLE:
        busy = 1'b0;
      LOAD0:
      begin
        final_addr = addr0_q;
        ren        = 1'b1;
      end
      LOAD1:
      begin
        final_addr = addr1_q;
        ren        = 1'b1;
      end
      STORE0:
      begin
        final_addr      = addr0_q;
        final_storedata = data0_q;
        wen             = 1'b1;
      end
      STORE1:
      begin
        final_addr      = addr1_q;
        final_storedata = data1_q;
        wen             = 1'b1;
      end
      EX:
      begin
        busy      = 1'b0;
        exception = 1'b1;
      end
      default:
        busy = 1'b0;
    endcase
  end

endmodule

// ==== src/load_aligner.sv ====
`timescale 1ns/1ns
`include "vlsu_params.svh"

module load_aligner
  import rv32v_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  arrived0,
  input  logic  arrived1,
  input  word_t rdata,
  input  sew_t  sew,
  output logic  result_valid,
  output word_t result0,
  output word_t result1
);

  // Current read data cut to the element width.
  word_t masked;

  // ************************************************************
  // Element masking.
  // ************************************************************

  // Zero extension only, no sign handling.
  function automatic word_t mask_elem(input word_t data, input sew_t width);
    word_t elem;
    case (width)
      `VLSU_SEW8:  elem = {{(`VLSU_WORD_W-8){1'b0}}, data[7:0]};
      `VLSU_SEW16: elem = {{(`VLSU_WORD_W-16){1'b0}}, data[15:0]};
      default:     elem = data;
    endcase
    return elem;
  endfunction

  assign masked = mask_elem(rdata, sew);

  // Element pair, held until the next load.
  always_ff @(posedge CLK)
  begin
    if (arrived0)
      result0 <= masked;
    if (arrived1)
      result1 <= masked;
  end

  // One cycle after the second hit.
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      result_valid <= 1'b0;
    else
      result_valid <= arrived1;
  end

endmodule

// ==== src/rv32v_types_pkg.sv ====
`include "vlsu_params.svh"

package rv32v_types_pkg;

  // ************************************************************
  // Vector load/store types.
  // ************************************************************

  // One data word on the memory port.
  typedef logic [`VLSU_WORD_W-1:0] word_t;

  // Byte address, word aligned for a legal access.
  typedef logic [`VLSU_WORD_W-1:0] addr_t;

  // Element width code, see VLSU_SEW* macros.
  typedef logic [1:0] sew_t;

  // Memory access size code, see VLSU_BENA* macros.
  typedef logic [1:0] byte_ena_t;

  // Scheduler FSM states.
  // LOAD0/STORE0 run the element at addr0.
  // LOAD1/STORE1 run the element at addr1.
  // EX holds until the core answers with returnex.
  typedef enum logic [2:0]
  {
    IDLE,
    LOAD0,
    LOAD1,
    STORE0,
    STORE1,
    EX
  } sched_state_t;

endpackage

// ==== src/vector_lsu.sv ====
`timescale 1ns/1ns
`include "vlsu_params.svh"

module vector_lsu
  import rv32v_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      cmd_valid,
  input  logic      cmd_load,
  input  logic      cmd_store,
  input  logic      dhit,
  input  logic      returnex,
  input  addr_t     base,
  input  addr_t     stride,
  input  sew_t      cmd_sew,
  input  word_t     cmd_data0,
  input  word_t     cmd_data1,
  input  word_t     mem_rdata,
  output logic      cmd_ready,
  output logic      busy,
  output logic      mem_ren,
  output logic      mem_wen,
  output logic      exception,
  output logic      result_valid,
  output addr_t     mem_addr,
  output word_t     mem_wdata,
  output byte_ena_t mem_byte_ena,
  output word_t     result0,
  output word_t     result1
);

  // Stage 1 to stage 2.
  logic  req_load;
  logic  req_store;
  logic  take;
  addr_t addr0;
  addr_t addr1;
  word_t storedata0;
  word_t storedata1;
  sew_t  sew;

  // Stage 2 to stage 3.
  logic  arrived0;
  logic  arrived1;

  // ************************************************************
  // Pipeline stages.
  // ************************************************************

  address_generator u_agen (
    .CLK        (CLK),
    .nRST       (nRST),
    .cmd_valid  (cmd_valid),
    .cmd_load   (cmd_load),
    .cmd_store  (cmd_store),
    .take       (take),
    .base       (base),
    .stride     (stride),
    .cmd_sew    (cmd_sew),
    .cmd_data0  (cmd_data0),
    .cmd_data1  (cmd_data1),
    .cmd_ready  (cmd_ready),
    .req_load   (req_load),
    .req_store  (req_store),
    .addr0      (addr0),
    .addr1      (addr1),
    .storedata0 (storedata0),
    .storedata1 (storedata1),
    .sew        (sew)
  );

  address_scheduler u_sched (
    .CLK             (CLK),
    .nRST            (nRST),
    .load            (req_load),
    .store           (req_store),
    .dhit            (dhit),
    .returnex        (returnex),
    .addr0           (addr0),
    .addr1           (addr1),
    .storedata0      (storedata0),
    .storedata1      (storedata1),
    .sew             (sew),
    .take            (take),
    .ren             (mem_ren),
    .wen             (mem_wen),
    .busy            (busy),
    .exception       (exception),
    .arrived0        (arrived0),
    .arrived1        (arrived1),
    .final_addr      (mem_addr),
    .final_storedata (mem_wdata),
    .byte_ena        (mem_byte_ena)
  );

  // Stage 1 may already hold the next command.
  // The access size code is the width of the load in flight.
  load_aligner u_align (
    .CLK          (CLK),
    .nRST         (nRST),
    .arrived0     (arrived0),
    .arrived1     (arrived1),
    .rdata        (mem_rdata),
    .sew          (mem_byte_ena),
    .result_valid (result_valid),
    .result0      (result0),
    .result1      (result1)
  );

endmodule

// ==== src/vlsu_params.svh ====
`ifndef VLSU_PARAMS_SVH
`define VLSU_PARAMS_SVH

// ************************************************************
// Widths shared by the whole load/store pipeline.
// ************************************************************

// Data word and byte address width.
`define VLSU_WORD_W 32

// Element width codes from the command.
`define VLSU_SEW8  2'd0
`define VLSU_SEW16 2'd1
`define VLSU_SEW32 2'd2

// Access size codes on the memory port.
// Same numbering as the element width codes.
`define VLSU_BENA8  2'd0
`define VLSU_BENA16 2'd1
`define VLSU_BENA32 2'd2

`endif

// ==== vlsu.f ====
+incdir+src
src/rv32v_types_pkg.sv
src/address_generator.sv
src/address_scheduler.sv
src/load_aligner.sv
src/vector_lsu.sv
bench/vector_lsu_properties.sv
bench/lsu_checker.sv
bench/vector_lsu_tb.sv
